// File: hdl/sms_pkg.sv
package sms_pkg;

  // =========================================================================
  // Bus and memory widths
  // =========================================================================

  localparam int CPU_ADDR_W  = 16;  // Z80 address bus
  localparam int DATA_W      = 8;
  localparam int PHASE_W     = 3;   // 8 cpuClock cycles per bus cycle

  localparam int CART_ADDR_W = 16;  // 64 KB cartridge
  localparam int BANK_W      = 2;   // Slot value bits that reach the cartridge
  localparam int RAM_ADDR_W  = 13;  // 8 KB work RAM
  localparam int VRAM_ADDR_W = 14;  // 16 KB VRAM

  localparam int VDP_REG_COUNT = 11;

  // =========================================================================
  // I/O port groups, address bits 7:6
  // =========================================================================

  localparam logic [1:0] PORT_GRP_MEMCTL = 2'd0;  // 00-3F
  localparam logic [1:0] PORT_GRP_PSG    = 2'd1;  // 40-7F
  localparam logic [1:0] PORT_GRP_VDP    = 2'd2;  // 80-BF, even data, odd control
  localparam logic [1:0] PORT_GRP_JOY    = 2'd3;  // C0-FF, even DC, odd DD

  // Mapper slot registers at the top of the RAM mirror
  localparam logic [CPU_ADDR_W-1:0] SLOT_ADDR_0 = 16'hFFFD;
  localparam logic [CPU_ADDR_W-1:0] SLOT_ADDR_1 = 16'hFFFE;
  localparam logic [CPU_ADDR_W-1:0] SLOT_ADDR_2 = 16'hFFFF;

  // =========================================================================
  // Cartridge time slots
  // =========================================================================

  // Phases 0-3 belong to the loader, the rest to CPU fetches
  localparam logic [PHASE_W-1:0] CPU_SLOT_START = 3'd4;

endpackage

// File: hdl/sms_bus_decode.sv
`timescale 1ns/1ps

module sms_bus_decode (
  input  logic                           cpuClock,
  input  logic                           n_hard_reset,
  input  logic [sms_pkg::CPU_ADDR_W-1:0] i_cpu_addr,
  input  logic                           i_n_mreq,
  input  logic                           i_n_iorq,
  input  logic                           i_n_rd,
  input  logic                           i_n_wr,
  input  logic [6:0]                     i_buttons,     // Active high
  input  logic [sms_pkg::DATA_W-1:0]     i_vdp_data,
  input  logic [sms_pkg::DATA_W-1:0]     i_vdp_status,
  input  logic [sms_pkg::DATA_W-1:0]     i_ram_data,
  input  logic [sms_pkg::DATA_W-1:0]     i_cart_data,
  output logic                           o_cpu_edge,
  output logic [sms_pkg::PHASE_W-1:0]    o_phase,
  output logic                           o_io_wr,
  output logic                           o_io_rd,
  output logic                           o_mem_wr,
  output logic                           o_mem_rd,
  output logic                           o_vdp_data_sel,
  output logic                           o_vdp_ctrl_sel,
  output logic [sms_pkg::DATA_W-1:0]     o_cpu_din
);

  logic [sms_pkg::PHASE_W-1:0] r_phase;
  logic [1:0]                  port_grp;
  logic                        joy0_sel;
  logic                        joy1_sel;
  logic [sms_pkg::DATA_W-1:0]  joy0_data;
  logic [sms_pkg::DATA_W-1:0]  joy1_data;
  logic                        cart_window;

  // Phase divider
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      r_phase <= '0;
    end else begin
      r_phase <= r_phase + 1'b1;
    end
  end

  assign o_phase    = r_phase;
  assign o_cpu_edge = &r_phase;  // Last phase, CPU samples here

  // Combined strobes, active high
  assign o_io_wr  = ~i_n_iorq & ~i_n_wr;
  assign o_io_rd  = ~i_n_iorq & ~i_n_rd;
  assign o_mem_wr = ~i_n_mreq & ~i_n_wr;
  assign o_mem_rd = ~i_n_mreq & ~i_n_rd;

  assign port_grp = i_cpu_addr[7:6];

  always_comb begin
    o_vdp_data_sel = 1'b0;
    o_vdp_ctrl_sel = 1'b0;
    joy0_sel       = 1'b0;
    joy1_sel       = 1'b0;
    case (port_grp)
      sms_pkg::PORT_GRP_VDP: begin
        o_vdp_data_sel = ~i_cpu_addr[0];
        o_vdp_ctrl_sel = i_cpu_addr[0];
      end
      sms_pkg::PORT_GRP_JOY: begin
        joy0_sel = ~i_cpu_addr[0];
        joy1_sel = i_cpu_addr[0];
      end
      sms_pkg::PORT_GRP_MEMCTL, sms_pkg::PORT_GRP_PSG: begin
        // No readable port in these groups
      end
    endcase
  end

  // Joypad bytes are active low on the bus
  assign joy0_data   = {2'b11, ~i_buttons[2:1], ~i_buttons[6:3]};
  assign joy1_data   = 8'hBF;
  assign cart_window = ~&i_cpu_addr[15:14];  // 0000-BFFF

  always_comb begin
    if (o_io_rd && o_vdp_data_sel)   o_cpu_din = i_vdp_data;
    else if (o_io_rd && o_vdp_ctrl_sel) o_cpu_din = i_vdp_status;
    else if (o_io_rd && joy0_sel)    o_cpu_din = joy0_data;
    else if (o_io_rd && joy1_sel)    o_cpu_din = joy1_data;
    else if (o_mem_rd && cart_window) o_cpu_din = i_cart_data;
    else                             o_cpu_din = i_ram_data;
  end

endmodule

// File: hdl/sms_vdp_port.sv
`timescale 1ns/1ps

module sms_vdp_port (
  input  logic                       cpuClock,
  input  logic                       n_hard_reset,
  input  logic                       i_cpu_edge,
  input  logic                       i_io_wr,
  input  logic                       i_io_rd,
  input  logic                       i_data_sel,
  input  logic                       i_ctrl_sel,
  input  logic [sms_pkg::DATA_W-1:0] i_cpu_dout,
  input  logic                       i_sprite_collision,
  input  logic                       i_frame_pulse,
  output logic [sms_pkg::DATA_W-1:0] o_vram_data,
  output logic [sms_pkg::DATA_W-1:0] o_status,
  output logic                       o_n_int
);

  logic                            data_wr;
  logic                            data_rd;
  logic                            ctrl_wr;
  logic                            ctrl_rd;
  logic                            reg_write;
  logic [3:0]                      reg_index;

  logic                            r_second_byte;  // Control latch toggle
  logic [sms_pkg::DATA_W-1:0]      r_first_byte;
  logic [sms_pkg::DATA_W-1:0]      r_vdp_reg [0:sms_pkg::VDP_REG_COUNT-1];
  logic [sms_pkg::VRAM_ADDR_W-1:0] r_addr;
  logic                            r_cram_sel;
  logic                            r_frame_flag;
  logic                            r_collision_flag;

  logic [sms_pkg::DATA_W-1:0]      vram [0:(2**sms_pkg::VRAM_ADDR_W)-1];
  logic [sms_pkg::DATA_W-1:0]      cram [0:31];
  logic [sms_pkg::DATA_W-1:0]      r_vram_q;
  logic [sms_pkg::DATA_W-1:0]      r_cram_q;

  assign data_wr = i_io_wr & i_data_sel;
  assign data_rd = i_io_rd & i_data_sel;
  assign ctrl_wr = i_io_wr & i_ctrl_sel;
  assign ctrl_rd = i_io_rd & i_ctrl_sel;

  // Second byte 10xx_rrrr with a valid register number
  assign reg_index = i_cpu_dout[3:0];
  assign reg_write = r_second_byte && (i_cpu_dout[7:6] == 2'b10) &&
                     (reg_index < 4'(sms_pkg::VDP_REG_COUNT));

  // =========================================================================
  // Control port and address
  // =========================================================================

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      r_second_byte <= 1'b0;
      r_addr        <= '0;
      r_cram_sel    <= 1'b0;
      for (int i = 0; i < sms_pkg::VDP_REG_COUNT; i++) begin
        r_vdp_reg[i] <= '0;
      end
    end else if (i_cpu_edge) begin
      if (data_wr || data_rd || ctrl_rd) begin
        r_second_byte <= 1'b0;
      end
      if (data_wr || data_rd) begin
        r_addr <= r_addr + 1'b1;  // Auto-increment once the access is sampled
      end
      if (ctrl_wr) begin
        r_second_byte <= ~r_second_byte;
        if (reg_write) begin
          r_vdp_reg[reg_index] <= r_first_byte;
        end else if (r_second_byte) begin
          r_addr     <= {i_cpu_dout[5:0], r_first_byte};
          r_cram_sel <= (i_cpu_dout[7:6] == 2'b11);  // CRAM code
        end
      end
    end
  end

  always_ff @(posedge cpuClock) begin
    if (i_cpu_edge && ctrl_wr && !r_second_byte) begin
      r_first_byte <= i_cpu_dout;
    end
  end

  // VRAM and CRAM, read port registered every cycle
  always_ff @(posedge cpuClock) begin
    if (i_cpu_edge && data_wr) begin
      if (r_cram_sel) begin
        cram[r_addr[4:0]] <= i_cpu_dout;
      end else begin
        vram[r_addr] <= i_cpu_dout;
      end
    end
    r_vram_q <= vram[r_addr];
    r_cram_q <= cram[r_addr[4:0]];
  end

  assign o_vram_data = r_cram_sel ? r_cram_q : r_vram_q;

  // =========================================================================
  // Status flags and interrupt
  // =========================================================================

  // A new pulse wins over the clear from a status read
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      r_frame_flag     <= 1'b0;
      r_collision_flag <= 1'b0;
    end else begin
      if (i_frame_pulse)               r_frame_flag <= 1'b1;
      else if (i_cpu_edge && ctrl_rd)  r_frame_flag <= 1'b0;
      if (i_sprite_collision)          r_collision_flag <= 1'b1;
      else if (i_cpu_edge && ctrl_rd)  r_collision_flag <= 1'b0;
    end
  end

  assign o_status = {r_frame_flag, 1'b0, r_collision_flag, 5'b11111};
  assign o_n_int  = ~(r_frame_flag & r_vdp_reg[1][5]);  // Frame IRQ enable

endmodule

// File: hdl/sms_memory_map.sv
`timescale 1ns/1ps

module sms_memory_map (
  input  logic                            cpuClock,
  input  logic                            n_hard_reset,
  input  logic                            i_cpu_edge,
  input  logic [sms_pkg::CPU_ADDR_W-1:0]  i_cpu_addr,
  input  logic [sms_pkg::DATA_W-1:0]      i_cpu_dout,
  input  logic                            i_mem_wr,
  input  logic                            i_mem_rd,
  output logic [sms_pkg::DATA_W-1:0]      o_ram_data,
  output logic                            o_cart_req,
  output logic [sms_pkg::CART_ADDR_W-1:0] o_cart_addr
);

  logic [sms_pkg::BANK_W-1:0]     r_slot0;
  logic [sms_pkg::BANK_W-1:0]     r_slot1;
  logic [sms_pkg::BANK_W-1:0]     r_slot2;
  logic [sms_pkg::BANK_W-1:0]     bank;

  logic [sms_pkg::DATA_W-1:0]     ram [0:(2**sms_pkg::RAM_ADDR_W)-1];
  logic [sms_pkg::DATA_W-1:0]     r_ram_q;
  logic [sms_pkg::RAM_ADDR_W-1:0] ram_addr;
  logic                           ram_window;

  assign ram_window = &i_cpu_addr[15:14];                     // C000-FFFF
  assign ram_addr   = i_cpu_addr[sms_pkg::RAM_ADDR_W-1:0];   // E000 mirrors C000

  // =========================================================================
  // Work RAM
  // =========================================================================

  always_ff @(posedge cpuClock) begin
    if (i_cpu_edge && i_mem_wr && ram_window) begin
      ram[ram_addr] <= i_cpu_dout;  // Slot writes land in RAM as well
    end
    r_ram_q <= ram[ram_addr];
  end

  assign o_ram_data = r_ram_q;

  // =========================================================================
  // Mapper
  // =========================================================================

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      r_slot0 <= sms_pkg::BANK_W'(0);
      r_slot1 <= sms_pkg::BANK_W'(1);
      r_slot2 <= sms_pkg::BANK_W'(2);
    end else if (i_cpu_edge && i_mem_wr) begin
      case (i_cpu_addr)
        sms_pkg::SLOT_ADDR_0: r_slot0 <= i_cpu_dout[sms_pkg::BANK_W-1:0];
        sms_pkg::SLOT_ADDR_1: r_slot1 <= i_cpu_dout[sms_pkg::BANK_W-1:0];
        sms_pkg::SLOT_ADDR_2: r_slot2 <= i_cpu_dout[sms_pkg::BANK_W-1:0];
        default: ;
      endcase
    end
  end

  // 16 KB window select
  always_comb begin
    case (i_cpu_addr[15:14])
      2'd0:    bank = r_slot0;
      2'd1:    bank = r_slot1;
      default: bank = r_slot2;  // RAM window has no fetch
    endcase
  end

  assign o_cart_addr = {bank, i_cpu_addr[13:0]};
  assign o_cart_req  = i_mem_rd & ~ram_window;

endmodule

// File: hdl/sms_cart_arbiter.sv
`timescale 1ns/1ps

module sms_cart_arbiter (
  input  logic                            cpuClock,
  input  logic                            n_hard_reset,
  input  logic [sms_pkg::PHASE_W-1:0]     i_phase,
  input  logic                            i_cart_req,
  input  logic [sms_pkg::CART_ADDR_W-1:0] i_cart_addr,
  input  logic                            i_load_valid,
  input  logic [sms_pkg::CART_ADDR_W-1:0] i_load_addr,
  input  logic [sms_pkg::DATA_W-1:0]      i_load_data,
  output logic [sms_pkg::DATA_W-1:0]      o_cart_data,
  output logic                            o_load_busy
);

  logic [sms_pkg::DATA_W-1:0]      cart [0:(2**sms_pkg::CART_ADDR_W)-1];
  logic [sms_pkg::DATA_W-1:0]      r_cart_q;

  logic                            r_pend_valid;
  logic [sms_pkg::CART_ADDR_W-1:0] r_pend_addr;
  logic [sms_pkg::DATA_W-1:0]      r_pend_data;

  logic                            load_grant;
  logic                            cpu_grant;
  logic                            fetch_now;
  logic [sms_pkg::CART_ADDR_W-1:0] mem_addr;

  // Fixed time slots, loader and CPU never share a phase
  assign load_grant = i_phase < sms_pkg::CPU_SLOT_START;
  assign cpu_grant  = ~load_grant;
  assign fetch_now  = cpu_grant && i_cart_req &&
                      (i_phase == sms_pkg::CPU_SLOT_START + 1'b1);  // Phase 5

  assign mem_addr = load_grant ? r_pend_addr : i_cart_addr;  // Single port

  // =========================================================================
  // Pending loader write
  // =========================================================================

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      r_pend_valid <= 1'b0;
    end else if (r_pend_valid) begin
      if (load_grant) begin
        r_pend_valid <= 1'b0;  // Written this cycle
      end
    end else if (i_load_valid) begin
      r_pend_valid <= 1'b1;
    end
  end

  // Strobes while busy are dropped
  always_ff @(posedge cpuClock) begin
    if (i_load_valid && !r_pend_valid) begin
      r_pend_addr <= i_load_addr;
      r_pend_data <= i_load_data;
    end
  end

  // =========================================================================
  // Cartridge store
  // =========================================================================

  always_ff @(posedge cpuClock) begin
    if (load_grant && r_pend_valid) begin
      cart[mem_addr] <= r_pend_data;
    end
    if (fetch_now) begin
      r_cart_q <= cart[mem_addr];  // Held until the next fetch
    end
  end

  assign o_cart_data = r_cart_q;
  assign o_load_busy = r_pend_valid;

endmodule

// File: hdl/sms_top.sv
`timescale 1ns/1ps

module sms_top (
  input  logic                            cpuClock,
  input  logic                            n_hard_reset,
  input  logic [sms_pkg::CPU_ADDR_W-1:0]  i_cpu_addr,
  input  logic [sms_pkg::DATA_W-1:0]      i_cpu_dout,
  input  logic                            i_n_mreq,
  input  logic                            i_n_iorq,
  input  logic                            i_n_rd,
  input  logic                            i_n_wr,
  input  logic [6:0]                      i_buttons,
  input  logic                            i_load_valid,
  input  logic [sms_pkg::CART_ADDR_W-1:0] i_load_addr,
  input  logic [sms_pkg::DATA_W-1:0]      i_load_data,
  input  logic                            i_sprite_collision,
  input  logic                            i_frame_pulse,
  output logic [sms_pkg::DATA_W-1:0]      o_cpu_din,
  output logic                            o_cpu_edge,
  output logic                            o_n_int,
  output logic                            o_load_busy
);

  logic [sms_pkg::PHASE_W-1:0]     phase;
  logic                            io_wr;
  logic                            io_rd;
  logic                            mem_wr;
  logic                            mem_rd;
  logic                            vdp_data_sel;
  logic                            vdp_ctrl_sel;
  logic [sms_pkg::DATA_W-1:0]      vram_data;
  logic [sms_pkg::DATA_W-1:0]      vdp_status;
  logic [sms_pkg::DATA_W-1:0]      ram_data;
  logic [sms_pkg::DATA_W-1:0]      cart_data;
  logic                            cart_req;
  logic [sms_pkg::CART_ADDR_W-1:0] cart_addr;

  // Phase, strobes, port selects and read mux
  sms_bus_decode u_bus_decode (
    .cpuClock(cpuClock), .n_hard_reset(n_hard_reset),
    .i_cpu_addr(i_cpu_addr), .i_n_mreq(i_n_mreq), .i_n_iorq(i_n_iorq),
    .i_n_rd(i_n_rd), .i_n_wr(i_n_wr), .i_buttons(i_buttons),
    .i_vdp_data(vram_data), .i_vdp_status(vdp_status),
    .i_ram_data(ram_data), .i_cart_data(cart_data),
    .o_cpu_edge(o_cpu_edge), .o_phase(phase),
    .o_io_wr(io_wr), .o_io_rd(io_rd), .o_mem_wr(mem_wr), .o_mem_rd(mem_rd),
    .o_vdp_data_sel(vdp_data_sel), .o_vdp_ctrl_sel(vdp_ctrl_sel),
    .o_cpu_din(o_cpu_din)
  );

  sms_vdp_port u_vdp_port (
    .cpuClock(cpuClock), .n_hard_reset(n_hard_reset), .i_cpu_edge(o_cpu_edge),
    .i_io_wr(io_wr), .i_io_rd(io_rd),
    .i_data_sel(vdp_data_sel), .i_ctrl_sel(vdp_ctrl_sel), .i_cpu_dout(i_cpu_dout),
    .i_sprite_collision(i_sprite_collision), .i_frame_pulse(i_frame_pulse),
    .o_vram_data(vram_data), .o_status(vdp_status), .o_n_int(o_n_int)
  );

  // Memory map and loader share the cartridge through the arbiter
  sms_memory_map u_memory_map (
    .cpuClock(cpuClock), .n_hard_reset(n_hard_reset), .i_cpu_edge(o_cpu_edge),
    .i_cpu_addr(i_cpu_addr), .i_cpu_dout(i_cpu_dout),
    .i_mem_wr(mem_wr), .i_mem_rd(mem_rd),
    .o_ram_data(ram_data), .o_cart_req(cart_req), .o_cart_addr(cart_addr)
  );

  sms_cart_arbiter u_cart_arbiter (
    .cpuClock(cpuClock), .n_hard_reset(n_hard_reset), .i_phase(phase),
    .i_cart_req(cart_req), .i_cart_addr(cart_addr),
    .i_load_valid(i_load_valid), .i_load_addr(i_load_addr), .i_load_data(i_load_data),
    .o_cart_data(cart_data), .o_load_busy(o_load_busy)
  );

endmodule

// File: sim/sms_sva.sv
`timescale 1ns/1ps

module sms_sva (
  input logic cpuClock,
  input logic n_hard_reset,
  input logic i_cpu_edge,
  input logic i_load_busy,
  input logic i_n_int
);

  int         fail_count = 0;
  logic [3:0] r_since_edge;  // Cycles since the last CPU edge
  logic [3:0] r_busy_len;
  logic       r_in_reset;

  always_ff @(posedge cpuClock) begin
    r_in_reset <= ~n_hard_reset;
    if (!n_hard_reset) begin
      r_since_edge <= 4'd0;
      r_busy_len   <= 4'd0;
    end else begin
      r_since_edge <= i_cpu_edge ? 4'd0 : r_since_edge + 4'd1;
      r_busy_len   <= i_load_busy ? r_busy_len + 4'd1 : 4'd0;
    end
  end

  // One CPU edge every 8 clocks
  a_edge_period: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    (i_cpu_edge |-> r_since_edge == 4'd7) and (r_since_edge == 4'd7 |-> i_cpu_edge))
    else begin
      $error("CPU edge spacing is not 8 cycles");
      fail_count++;
    end

  a_busy_bound: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    i_load_busy |-> r_busy_len < 4'd8)
    else begin
      $error("Loader busy held longer than 8 cycles");
      fail_count++;
    end

  a_int_reset: assert property (@(posedge cpuClock)
    (r_in_reset && !n_hard_reset) |-> i_n_int)
    else begin
      $error("Interrupt asserted during reset");
      fail_count++;
    end

endmodule

bind sms_top sms_sva u_sms_sva (
  .cpuClock(cpuClock), .n_hard_reset(n_hard_reset), .i_cpu_edge(o_cpu_edge),
  .i_load_busy(o_load_busy), .i_n_int(o_n_int)
);

// File: sim/tb_sms.sv
`timescale 1ns/1ps

module tb_sms;

  // ==========================================================================
  // Test sizes and run limit
  // ==========================================================================

  localparam int RAM_OPS      = 32;
  localparam int LOAD_COUNT   = 32;
  localparam int CART_OPS     = 24;
  localparam int BURST        = 16;
  localparam int JOY_OPS      = 8;
  localparam int FIXED_CYCLES = 24;  // Status, interrupt and realignment cycles
  localparam int BUS_CYCLES   = 2*RAM_OPS + 2*CART_OPS + 2*(BURST + 2) + 2*JOY_OPS
                                + FIXED_CYCLES;
  localparam int LOAD_TIME    = LOAD_COUNT * 12;  // Strobe plus worst busy time
  localparam int MAX_CYCLES   = 2 * (BUS_CYCLES * 8 + LOAD_TIME) + 32;

  logic        cpuClock;
  logic        n_hard_reset;
  logic [15:0] i_cpu_addr;
  logic [7:0]  i_cpu_dout;
  logic        i_n_mreq;
  logic        i_n_iorq;
  logic        i_n_rd;
  logic        i_n_wr;
  logic [6:0]  i_buttons;
  logic        i_load_valid;
  logic [15:0] i_load_addr;
  logic [7:0]  i_load_data;
  logic        i_sprite_collision;
  logic        i_frame_pulse;
  logic [7:0]  o_cpu_din;
  logic        o_cpu_edge;
  logic        o_n_int;
  logic        o_load_busy;

  // Reference model
  logic [7:0]  ram_model  [0:8191];
  logic [7:0]  cart_model [0:65535];
  logic [7:0]  vram_model [0:16383];
  logic [1:0]  slot_model [0:2];
  logic [7:0]  reg1_model;
  logic        frame_model;
  logic        coll_model;

  logic [15:0] load_addrs [$];
  logic [7:0]  load_datas [$];
  logic [12:0] ram_offs [$];

  logic [15:0] addr;
  logic [7:0]  data;
  logic [7:0]  din;
  logic [12:0] off;
  logic [13:0] vaddr;
  logic [6:0]  buttons;
  int          w;
  int          idx;
  int          errors = 0;
  int          checks = 0;
  int          cycle_count = 0;

  sms_top u_sms_top (
    .cpuClock(cpuClock), .n_hard_reset(n_hard_reset),
    .i_cpu_addr(i_cpu_addr), .i_cpu_dout(i_cpu_dout),
    .i_n_mreq(i_n_mreq), .i_n_iorq(i_n_iorq), .i_n_rd(i_n_rd), .i_n_wr(i_n_wr),
    .i_buttons(i_buttons), .i_load_valid(i_load_valid),
    .i_load_addr(i_load_addr), .i_load_data(i_load_data),
    .i_sprite_collision(i_sprite_collision), .i_frame_pulse(i_frame_pulse),
    .o_cpu_din(o_cpu_din), .o_cpu_edge(o_cpu_edge),
    .o_n_int(o_n_int), .o_load_busy(o_load_busy)
  );

  initial begin
    cpuClock = 1'b0;
    forever #20 cpuClock = ~cpuClock;
  end

  always @(posedge cpuClock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ==========================================================================
  // Bus tasks, each starts on the clock after a CPU edge
  // ==========================================================================

  task automatic compare_byte(input string what, input logic [7:0] got,
                              input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s read %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic bus_cycle(input logic [15:0] a, input logic [7:0] dout,
                           input logic is_io, input logic is_wr, output logic [7:0] rd);
    i_cpu_addr <= a;
    i_cpu_dout <= dout;
    i_n_mreq   <= is_io;
    i_n_iorq   <= ~is_io;
    i_n_rd     <= is_wr;
    i_n_wr     <= ~is_wr;
    @(posedge cpuClock);
    while (!o_cpu_edge) @(posedge cpuClock);
    rd = o_cpu_din;  // Sampled on the edge cycle
  endtask

  task automatic mem_write(input logic [15:0] a, input logic [7:0] d);
    logic [7:0] ignored;
    bus_cycle(a, d, 1'b0, 1'b1, ignored);
  endtask

  task automatic mem_read(input logic [15:0] a, output logic [7:0] rd);
    bus_cycle(a, 8'h00, 1'b0, 1'b0, rd);
  endtask

  task automatic io_write(input logic [7:0] port, input logic [7:0] d);
    logic [7:0] ignored;
    bus_cycle({8'h00, port}, d, 1'b1, 1'b1, ignored);
  endtask

  task automatic io_read(input logic [7:0] port, output logic [7:0] rd);
    bus_cycle({8'h00, port}, 8'h00, 1'b1, 1'b0, rd);
  endtask

  // Bus idle for one cycle with optional renderer pulses
  task automatic idle_cycle(input logic frame, input logic coll);
    i_n_mreq           <= 1'b1;
    i_n_iorq           <= 1'b1;
    i_n_rd             <= 1'b1;
    i_n_wr             <= 1'b1;
    i_frame_pulse      <= frame;
    i_sprite_collision <= coll;
    @(posedge cpuClock);
    i_frame_pulse      <= 1'b0;
    i_sprite_collision <= 1'b0;
    if (frame) frame_model = 1'b1;
    if (coll) coll_model = 1'b1;
    while (!o_cpu_edge) @(posedge cpuClock);
  endtask

  task automatic load_byte(input logic [15:0] a, input logic [7:0] d);
    i_load_valid <= 1'b1;
    i_load_addr  <= a;
    i_load_data  <= d;
    @(posedge cpuClock);
    i_load_valid <= 1'b0;
    @(posedge cpuClock);
    compare_byte("load busy", {7'd0, o_load_busy}, 8'h01);  // Cycle after the strobe
    while (o_load_busy) @(posedge cpuClock);
  endtask

  task automatic write_vdp_reg(input logic [3:0] index, input logic [7:0] value);
    io_write(8'hBF, value);
    io_write(8'hBF, {4'b1000, index});
    if (index == 4'd1) reg1_model = value;
  endtask

  task automatic read_status();
    logic [7:0] value;
    io_read(8'hBF, value);
    compare_byte("VDP status", value, {frame_model, 1'b0, coll_model, 5'b11111});
    frame_model = 1'b0;  // Flags clear at the read edge
    coll_model  = 1'b0;
  endtask

  task automatic check_int();
    compare_byte("n_int", {7'd0, o_n_int}, {7'd0, ~(frame_model & reg1_model[5])});
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================

  initial begin
    n_hard_reset       = 1'b0;
    i_cpu_addr         = 16'h0000;
    i_cpu_dout         = 8'h00;
    i_n_mreq           = 1'b1;
    i_n_iorq           = 1'b1;
    i_n_rd             = 1'b1;
    i_n_wr             = 1'b1;
    i_buttons          = 7'h00;
    i_load_valid       = 1'b0;
    i_load_addr        = 16'h0000;
    i_load_data        = 8'h00;
    i_sprite_collision = 1'b0;
    i_frame_pulse      = 1'b0;
    slot_model[0]      = 2'd0;
    slot_model[1]      = 2'd1;
    slot_model[2]      = 2'd2;
    reg1_model         = 8'h00;
    frame_model        = 1'b0;
    coll_model         = 1'b0;
    void'($urandom(32'h709));

    repeat (16) @(posedge cpuClock);
    n_hard_reset <= 1'b1;
    @(posedge cpuClock);
    while (!o_cpu_edge) @(posedge cpuClock);

    // Outputs idle after reset
    compare_byte("load busy", {7'd0, o_load_busy}, 8'h00);
    compare_byte("n_int", {7'd0, o_n_int}, 8'h01);

    // Work RAM writes, FFFD-FFFF avoided
    for (int i = 0; i < RAM_OPS; i++) begin
      off  = 13'($urandom);
      addr = {2'b11, 1'($urandom), off};
      if (addr >= 16'hFFFD) addr[13] = 1'b0;
      data = 8'($urandom);
      mem_write(addr, data);
      ram_model[off] = data;
      ram_offs.push_back(off);
    end

    for (int k = 0; k < LOAD_COUNT; k++) begin
      load_addrs.push_back(16'($urandom));
      load_datas.push_back(8'($urandom));
      cart_model[load_addrs[k]] = load_datas[k];
    end

    // Loader fills the cartridge while the CPU reads back RAM
    fork
      begin
        for (int k = 0; k < LOAD_COUNT; k++) begin
          load_byte(load_addrs[k], load_datas[k]);
        end
      end
      begin
        for (int i = 0; i < RAM_OPS; i++) begin
          off  = ram_offs[i];
          addr = {2'b11, i[0], off};  // Odd reads through E000
          mem_read(addr, din);
          compare_byte($sformatf("RAM %04h", addr), din, ram_model[off]);
        end
      end
    join
    idle_cycle(1'b0, 1'b0);  // Back in step with the bus

    // Mapper slots and cartridge windows
    for (int n = 0; n < CART_OPS; n++) begin
      idx  = $urandom % load_addrs.size();
      w    = $urandom % 3;
      data = {6'($urandom), load_addrs[idx][15:14]};
      mem_write(16'hFFFD + 16'(w), data);
      slot_model[w] = data[1:0];
      ram_model[13'h1FFD + 13'(w)] = data;  // Slot writes reach RAM too
      addr = {2'(w), load_addrs[idx][13:0]};
      mem_read(addr, din);
      compare_byte($sformatf("cart %04h", addr), din,
                   cart_model[{slot_model[w], addr[13:0]}]);
    end

    // VRAM burst through auto-increment
    vaddr = 14'($urandom);
    io_write(8'hBF, vaddr[7:0]);
    io_write(8'hBF, {2'b01, vaddr[13:8]});
    for (int i = 0; i < BURST; i++) begin
      data = 8'($urandom);
      io_write(8'hBE, data);
      vram_model[vaddr] = data;
      vaddr = vaddr + 14'd1;
    end
    vaddr = vaddr - 14'(BURST);
    io_write(8'hBF, vaddr[7:0]);
    io_write(8'hBF, {2'b00, vaddr[13:8]});
    for (int i = 0; i < BURST; i++) begin
      io_read(8'hBE, din);
      compare_byte($sformatf("VRAM %04h", vaddr), din, vram_model[vaddr]);
      vaddr = vaddr + 14'd1;
    end

    // Status flags
    read_status();
    idle_cycle(1'b1, 1'b1);
    read_status();
    read_status();

    // Frame interrupt with and without the enable
    write_vdp_reg(4'd1, 8'h20);
    read_status();
    idle_cycle(1'b1, 1'b0);
    check_int();
    read_status();
    idle_cycle(1'b0, 1'b0);
    check_int();
    write_vdp_reg(4'd1, 8'h00);
    idle_cycle(1'b1, 1'b0);
    check_int();
    read_status();
    idle_cycle(1'b0, 1'b0);
    check_int();

    // Joypad ports
    for (int i = 0; i < JOY_OPS; i++) begin
      buttons = 7'($urandom);
      i_buttons <= buttons;
      io_read(8'hDC, din);
      compare_byte("port DC", din, {2'b11, ~buttons[2:1], ~buttons[6:3]});
      io_read(8'hDD, din);
      compare_byte("port DD", din, 8'hBF);
    end

    $display("Run complete: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, u_sms_top.u_sms_sva.fail_count);
    if (errors == 0 && u_sms_top.u_sms_sva.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
hdl/sms_pkg.sv
hdl/sms_bus_decode.sv
hdl/sms_vdp_port.sv
hdl/sms_memory_map.sv
hdl/sms_cart_arbiter.sv
hdl/sms_top.sv
sim/sms_sva.sv
sim/tb_sms.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

TOP=tb_sms
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/V"$TOP" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
  echo "Result: pass"
  exit 0
fi

echo "Result: fail"
exit 1
